//--- design/sram_bist_pkg.sv
package sram_bist_pkg;

  localparam int addr_w = 8;
  localparam int data_w = 16;

  typedef logic [addr_w-1:0] addr_t;
  typedef logic [data_w-1:0] data_t;
  typedef logic [2:0]        pat_t;

  // pattern sequence, run in index order
  localparam int   num_patterns    = 6;
  localparam pat_t pat_zeros       = 3'd0;
  localparam pat_t pat_ones        = 3'd1;
  localparam pat_t pat_checker     = 3'd2;
  localparam pat_t pat_checker_inv = 3'd3;
  localparam pat_t pat_addr        = 3'd4;
  localparam pat_t pat_seed_addr   = 3'd5;

  // checkerboard word at even addresses, odd ones get the inverse
  localparam data_t checker_even = 16'h5555;

  // async SRAM strobe timing, in clock cycles
  localparam int write_cycles = 2;
  localparam int read_cycles  = 2;
  typedef logic [2:0] cyc_t;

  // expected-data FIFO, pointers carry one extra wrap bit
  localparam int fifo_depth = 4;
  localparam int fifo_ptr_w = $clog2(fifo_depth);
  typedef logic [fifo_ptr_w:0] fifo_cnt_t;

endpackage

//--- design/axil_if.sv
`timescale 1ns/1ns

interface axil_if;

  // write address
  sram_bist_pkg::addr_t awaddr;
  logic                 awvalid;
  logic                 awready;

  // write data, strobes always full
  sram_bist_pkg::data_t wdata;
  logic                 wvalid;
  logic                 wready;

  // write response, always OKAY so no resp field
  logic                 bvalid;
  logic                 bready;

  // read address
  sram_bist_pkg::addr_t araddr;
  logic                 arvalid;
  logic                 arready;

  // read data
  sram_bist_pkg::data_t rdata;
  logic                 rvalid;
  logic                 rready;

  modport master (
    output awaddr, awvalid, input awready,
    output wdata, wvalid, input wready,
    input bvalid, output bready,
    output araddr, arvalid, input arready,
    input rdata, rvalid, output rready
  );

  modport slave (
    input awaddr, awvalid, output awready,
    input wdata, wvalid, output wready,
    output bvalid, input bready,
    input araddr, arvalid, output arready,
    output rdata, rvalid, input rready
  );

  // observes read responses only
  modport monitor (
    input rdata, rvalid, rready
  );

endinterface

//--- design/sram_axil_ctrl.sv
`timescale 1ns/1ns

module sram_axil_ctrl (
  input  logic                      clk,
  input  logic                      reset,
  axil_if.slave                     bus,
  output sram_bist_pkg::addr_t      sram_addr,
  inout  wire sram_bist_pkg::data_t sram_data,
  output logic                      sram_we_n,
  output logic                      sram_oe_n,
  output logic                      sram_ce_n
);

  typedef enum logic [2:0] {idle, write, write_resp, read, read_resp} state_t;

  state_t               state;
  sram_bist_pkg::cyc_t  cnt;
  sram_bist_pkg::data_t wdata_q;
  logic                 wr_accept;
  logic                 rd_accept;
  logic                 rd_capture;

  // writes win if both channels show up in the same idle cycle
  assign wr_accept = (state == idle) && bus.awvalid && bus.wvalid;
  assign rd_accept = (state == idle) && bus.arvalid && !wr_accept;

  assign bus.awready = wr_accept;
  assign bus.wready  = wr_accept;
  assign bus.arready = rd_accept;

  assign rd_capture = (state == read) &&
                      (cnt == sram_bist_pkg::cyc_t'(sram_bist_pkg::read_cycles - 1));

  // data stays driven one cycle past the we_n rising edge for hold
  assign sram_data = (state == write) ? wdata_q : 'z;

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= idle;
      cnt        <= '0;
      sram_we_n  <= 1'b1;
      sram_oe_n  <= 1'b1;
      sram_ce_n  <= 1'b1;
      bus.bvalid <= 1'b0;
      bus.rvalid <= 1'b0;
    end else begin
      case (state)
        idle: begin
          cnt <= '0;
          if (wr_accept) begin
            state     <= write;
            sram_we_n <= 1'b0;
            sram_ce_n <= 1'b0;
          end else if (rd_accept) begin
            state     <= read;
            sram_oe_n <= 1'b0;
            sram_ce_n <= 1'b0;
          end
        end
        write: begin
          cnt <= cnt + 1'b1;
          if (cnt == sram_bist_pkg::cyc_t'(sram_bist_pkg::write_cycles - 1)) begin
            sram_we_n <= 1'b1;
            sram_ce_n <= 1'b1;
          end
          if (cnt == sram_bist_pkg::cyc_t'(sram_bist_pkg::write_cycles)) begin
            state      <= write_resp;
            bus.bvalid <= 1'b1;
          end
        end
        write_resp: begin
          if (bus.bready) begin
            state      <= idle;
            bus.bvalid <= 1'b0;
          end
        end
        read: begin
          cnt <= cnt + 1'b1;
          if (rd_capture) begin
            state      <= read_resp;
            sram_oe_n  <= 1'b1;
            sram_ce_n  <= 1'b1;
            bus.rvalid <= 1'b1;
          end
        end
        read_resp: begin
          if (bus.rready) begin
            state      <= idle;
            bus.rvalid <= 1'b0;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // address, write word and captured read word
  always_ff @(posedge clk) begin
    if (wr_accept) begin
      sram_addr <= bus.awaddr;
      wdata_q   <= bus.wdata;
    end else if (rd_accept) begin
      sram_addr <= bus.araddr;
    end
    if (rd_capture) begin
      bus.rdata <= sram_data;
    end
  end

  a_one_response: assert property (@(posedge clk) disable iff (reset)
    !(bus.bvalid && bus.rvalid));

  a_strobe_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(!sram_we_n && !sram_oe_n));

endmodule

//--- design/pattern_gen.sv
`timescale 1ns/1ns

module pattern_gen (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 first,
  input  logic                 next,
  input  sram_bist_pkg::data_t seed,
  input  sram_bist_pkg::addr_t addr,
  output sram_bist_pkg::pat_t  pat,
  output sram_bist_pkg::data_t data,
  output logic                 last
);

  sram_bist_pkg::data_t seed_q;
  sram_bist_pkg::data_t addr_word;
  sram_bist_pkg::data_t checker_word;

  assign last = (pat == sram_bist_pkg::pat_t'(sram_bist_pkg::num_patterns - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      pat <= '0;
    end else if (first) begin
      pat <= '0;
    end else if (next && !last) begin
      pat <= pat + 1'b1;
    end
  end

  // seed only matters for the last pattern and is held for the whole run
  always_ff @(posedge clk) begin
    if (first) begin
      seed_q <= seed;
    end
  end

  assign addr_word    = sram_bist_pkg::data_t'(addr);
  assign checker_word = addr[0] ? ~sram_bist_pkg::checker_even : sram_bist_pkg::checker_even;

  always_comb begin
    case (pat)
      sram_bist_pkg::pat_zeros:       data = '0;
      sram_bist_pkg::pat_ones:        data = '1;
      sram_bist_pkg::pat_checker:     data = checker_word;
      sram_bist_pkg::pat_checker_inv: data = ~checker_word;
      sram_bist_pkg::pat_addr:        data = addr_word;
      sram_bist_pkg::pat_seed_addr:   data = seed_q ^ addr_word;
      default:                        data = '0;
    endcase
  end

endmodule

//--- design/bist_sequencer.sv
`timescale 1ns/1ns

module bist_sequencer (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 start,
  input  sram_bist_pkg::data_t seed,
  axil_if.master               bus,
  output logic                 fifo_push,
  output sram_bist_pkg::data_t fifo_data,
  output sram_bist_pkg::addr_t fifo_addr,
  input  logic                 fifo_full,
  input  logic                 fifo_empty,
  input  logic                 fail,
  output logic                 done,
  output sram_bist_pkg::pat_t  pat
);

  typedef enum logic [2:0] {
    idle, write_pass, wait_writes, read_pass, wait_reads, next_pattern, finish
  } state_t;

  state_t                   state;
  sram_bist_pkg::addr_t     addr;
  sram_bist_pkg::fifo_cnt_t in_flight;
  sram_bist_pkg::data_t     pg_data;
  logic                     pg_first;
  logic                     pg_next;
  logic                     pg_last;
  logic                     wr_busy;
  logic                     issue_write;
  logic                     issue_read;
  logic                     aw_fire;
  logic                     w_fire;
  logic                     b_fire;
  logic                     ar_fire;
  logic                     r_fire;

  pattern_gen pattern_gen_inst (
    .clk   (clk),
    .reset (reset),
    .first (pg_first),
    .next  (pg_next),
    .seed  (seed),
    .addr  (addr),
    .pat   (pat),
    .data  (pg_data),
    .last  (pg_last)
  );

  assign pg_first = (state == idle) && start;
  assign pg_next  = (state == next_pattern);

  assign aw_fire = bus.awvalid && bus.awready;
  assign w_fire  = bus.wvalid && bus.wready;
  assign b_fire  = bus.bvalid && bus.bready;
  assign ar_fire = bus.arvalid && bus.arready;
  assign r_fire  = bus.rvalid && bus.rready;

  // one write at a time, reads pipeline behind the accepted address
  assign issue_write = (state == write_pass) && !wr_busy;
  assign issue_read  = (state == read_pass) && !fail && !fifo_full &&
                       (!bus.arvalid || ar_fire);

  // expected word enters the FIFO as the read address is issued
  assign fifo_push = issue_read;
  assign fifo_data = pg_data;
  assign fifo_addr = addr;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= idle;
      addr  <= '0;
      done  <= 1'b0;
    end else begin
      case (state)
        idle: begin
          if (start) begin
            state <= write_pass;
            addr  <= '0;
            done  <= 1'b0;
          end
        end
        write_pass: begin
          if (issue_write) begin
            addr <= addr + 1'b1;
            if (addr == '1) state <= wait_writes;
          end
        end
        wait_writes: begin
          if (!wr_busy) state <= read_pass;
        end
        read_pass: begin
          // on a failure stop issuing, the pending address still completes
          if (fail) begin
            state <= wait_reads;
          end else if (issue_read) begin
            addr <= addr + 1'b1;
            if (addr == '1) state <= wait_reads;
          end
        end
        wait_reads: begin
          if (in_flight == '0 && fifo_empty) begin
            state <= (fail || pg_last) ? finish : next_pattern;
          end
        end
        next_pattern: state <= write_pass;
        finish: begin
          done  <= 1'b1;
          state <= idle;
        end
        default: state <= idle;
      endcase
    end
  end

  // channel valids, response readies held high
  always_ff @(posedge clk) begin
    if (reset) begin
      bus.awvalid <= 1'b0;
      bus.wvalid  <= 1'b0;
      bus.arvalid <= 1'b0;
      bus.bready  <= 1'b0;
      bus.rready  <= 1'b0;
      wr_busy     <= 1'b0;
    end else begin
      bus.bready <= 1'b1;
      bus.rready <= 1'b1;
      if (aw_fire) bus.awvalid <= 1'b0;
      if (w_fire) bus.wvalid <= 1'b0;
      if (b_fire) wr_busy <= 1'b0;
      if (issue_write) begin
        bus.awvalid <= 1'b1;
        bus.wvalid  <= 1'b1;
        wr_busy     <= 1'b1;
      end
      if (ar_fire) bus.arvalid <= 1'b0;
      if (issue_read) bus.arvalid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_write) begin
      bus.awaddr <= addr;
      bus.wdata  <= pg_data;
    end
    if (issue_read) begin
      bus.araddr <= addr;
    end
  end

  // reads issued but not yet answered
  always_ff @(posedge clk) begin
    if (reset) begin
      in_flight <= '0;
    end else begin
      case ({issue_read, r_fire})
        2'b10:   in_flight <= in_flight + 1'b1;
        2'b01:   in_flight <= in_flight - 1'b1;
        default: in_flight <= in_flight;
      endcase
    end
  end

endmodule

//--- design/expected_fifo.sv
`timescale 1ns/1ns

module expected_fifo (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 push,
  input  sram_bist_pkg::data_t push_data,
  input  sram_bist_pkg::addr_t push_addr,
  input  logic                 pop,
  output sram_bist_pkg::data_t pop_data,
  output sram_bist_pkg::addr_t pop_addr,
  output logic                 full,
  output logic                 empty
);

  sram_bist_pkg::data_t     data_mem [sram_bist_pkg::fifo_depth];
  sram_bist_pkg::addr_t     addr_mem [sram_bist_pkg::fifo_depth];
  sram_bist_pkg::fifo_cnt_t wr_ptr;
  sram_bist_pkg::fifo_cnt_t rd_ptr;

  // same slot, wrap bits differ when full
  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[sram_bist_pkg::fifo_ptr_w] != rd_ptr[sram_bist_pkg::fifo_ptr_w]) &&
                 (wr_ptr[sram_bist_pkg::fifo_ptr_w-1:0] == rd_ptr[sram_bist_pkg::fifo_ptr_w-1:0]);

  assign pop_data = data_mem[rd_ptr[sram_bist_pkg::fifo_ptr_w-1:0]];
  assign pop_addr = addr_mem[rd_ptr[sram_bist_pkg::fifo_ptr_w-1:0]];

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      data_mem[wr_ptr[sram_bist_pkg::fifo_ptr_w-1:0]] <= push_data;
      addr_mem[wr_ptr[sram_bist_pkg::fifo_ptr_w-1:0]] <= push_addr;
    end
  end

  // sequencer must respect full, checker pops only for issued reads
  a_no_overflow: assert property (@(posedge clk) disable iff (reset) push |-> !full);
  a_no_underflow: assert property (@(posedge clk) disable iff (reset) pop |-> !empty);

endmodule

//--- design/read_checker.sv
`timescale 1ns/1ns

module read_checker (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 start,
  axil_if.monitor              bus,
  input  sram_bist_pkg::data_t exp_data,
  input  sram_bist_pkg::addr_t exp_addr,
  output logic                 pop,
  output logic                 fail,
  output sram_bist_pkg::addr_t fail_addr,
  output sram_bist_pkg::data_t fail_data
);

  logic mismatch;

  // every read response retires one FIFO entry
  assign pop      = bus.rvalid && bus.rready;
  assign mismatch = pop && (bus.rdata != exp_data);

  always_ff @(posedge clk) begin
    if (reset || start) begin
      fail      <= 1'b0;
      fail_addr <= '0;
      fail_data <= '0;
    end else if (mismatch && !fail) begin
      // first failure only, later ones are ignored
      fail      <= 1'b1;
      fail_addr <= exp_addr;
      fail_data <= bus.rdata;
    end
  end

endmodule

//--- design/sram_bist_top.sv
`timescale 1ns/1ns

module sram_bist_top (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      start,
  input  sram_bist_pkg::data_t      seed,
  output logic                      done,
  output logic                      pass,
  output logic                      fail,
  output sram_bist_pkg::addr_t      fail_addr,
  output sram_bist_pkg::data_t      fail_data,
  output sram_bist_pkg::pat_t       fail_pattern,
  output sram_bist_pkg::addr_t      sram_addr,
  inout  wire sram_bist_pkg::data_t sram_data,
  output logic                      sram_we_n,
  output logic                      sram_oe_n,
  output logic                      sram_ce_n
);

  logic                 fifo_push;
  logic                 fifo_pop;
  logic                 fifo_full;
  logic                 fifo_empty;
  sram_bist_pkg::data_t fifo_push_data;
  sram_bist_pkg::addr_t fifo_push_addr;
  sram_bist_pkg::data_t fifo_pop_data;
  sram_bist_pkg::addr_t fifo_pop_addr;
  logic                 checker_start;

  axil_if bus ();

  // done is only high while the sequencer sits idle, so a start during a
  // run cannot wipe the latched failure
  assign checker_start = start && done;
  assign pass          = done && !fail;

  bist_sequencer bist_sequencer_inst (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .seed       (seed),
    .bus        (bus),
    .fifo_push  (fifo_push),
    .fifo_data  (fifo_push_data),
    .fifo_addr  (fifo_push_addr),
    .fifo_full  (fifo_full),
    .fifo_empty (fifo_empty),
    .fail       (fail),
    .done       (done),
    .pat        (fail_pattern)
  );

  sram_axil_ctrl sram_axil_ctrl_inst (
    .clk       (clk),
    .reset     (reset),
    .bus       (bus),
    .sram_addr (sram_addr),
    .sram_data (sram_data),
    .sram_we_n (sram_we_n),
    .sram_oe_n (sram_oe_n),
    .sram_ce_n (sram_ce_n)
  );

  expected_fifo expected_fifo_inst (
    .clk       (clk),
    .reset     (reset),
    .push      (fifo_push),
    .push_data (fifo_push_data),
    .push_addr (fifo_push_addr),
    .pop       (fifo_pop),
    .pop_data  (fifo_pop_data),
    .pop_addr  (fifo_pop_addr),
    .full      (fifo_full),
    .empty     (fifo_empty)
  );

  read_checker read_checker_inst (
    .clk       (clk),
    .reset     (reset),
    .start     (checker_start),
    .bus       (bus),
    .exp_data  (fifo_pop_data),
    .exp_addr  (fifo_pop_addr),
    .pop       (fifo_pop),
    .fail      (fail),
    .fail_addr (fail_addr),
    .fail_data (fail_data)
  );

endmodule

//--- verif/sram_model.sv
`timescale 1ns/1ns

module sram_model (
  input  sram_bist_pkg::addr_t      addr,
  inout  wire sram_bist_pkg::data_t data,
  input  logic                      we_n,
  input  logic                      oe_n,
  input  logic                      ce_n,
  input  logic                      fault_on,
  input  sram_bist_pkg::addr_t      fault_addr,
  input  logic [3:0]                fault_bit,
  input  logic                      fault_val
);

  sram_bist_pkg::data_t mem [2**sram_bist_pkg::addr_w];
  sram_bist_pkg::data_t rd_word;
  logic                 drive;

  // cell takes the bus value as we_n rises, data is still held then
  always @(posedge we_n) begin
    mem[addr] <= data;
  end

  // stuck-at bit shows up on reads of the faulty cell only
  always_comb begin
    rd_word = mem[addr];
    if (fault_on && (addr == fault_addr)) begin
      rd_word[fault_bit] = fault_val;
    end
  end

  assign drive = !ce_n && !oe_n && we_n;
  assign data  = drive ? rd_word : 'z;

endmodule

//--- verif/tb_sram_bist.sv
`timescale 1ns/1ns

module tb_sram_bist;

  localparam int run_limit       = 6 * 512 * 8;
  localparam int num_runs        = 6;
  localparam int watchdog_cycles = num_runs * run_limit + 2000;

  logic                 clk = 1'b0;
  logic                 reset;
  logic                 start;
  sram_bist_pkg::data_t seed;
  logic                 done;
  logic                 pass;
  logic                 fail;
  sram_bist_pkg::addr_t fail_addr;
  sram_bist_pkg::data_t fail_data;
  sram_bist_pkg::pat_t  fail_pattern;
  sram_bist_pkg::addr_t sram_addr;
  wire  sram_bist_pkg::data_t sram_data;
  logic                 sram_we_n;
  logic                 sram_oe_n;
  logic                 sram_ce_n;

  // injected fault
  logic                 fault_en;
  logic                 fault_live;
  sram_bist_pkg::addr_t fault_addr;
  logic [3:0]           fault_bit;
  logic                 fault_val;

  string test_name;
  int    test_errors;
  int    errors;
  int    tests;
  int    pin_errors = 0;

  sram_bist_top sram_bist_top_inst (
    .clk          (clk),
    .reset        (reset),
    .start        (start),
    .seed         (seed),
    .done         (done),
    .pass         (pass),
    .fail         (fail),
    .fail_addr    (fail_addr),
    .fail_data    (fail_data),
    .fail_pattern (fail_pattern),
    .sram_addr    (sram_addr),
    .sram_data    (sram_data),
    .sram_we_n    (sram_we_n),
    .sram_oe_n    (sram_oe_n),
    .sram_ce_n    (sram_ce_n)
  );

  sram_model sram_model_inst (
    .addr       (sram_addr),
    .data       (sram_data),
    .we_n       (sram_we_n),
    .oe_n       (sram_oe_n),
    .ce_n       (sram_ce_n),
    .fault_on   (fault_live),
    .fault_addr (fault_addr),
    .fault_bit  (fault_bit),
    .fault_val  (fault_val)
  );

  always #5 clk = ~clk;

  // strobes must never overlap
  always @(negedge clk) begin
    if (!reset && !sram_we_n && !sram_oe_n) begin
      pin_errors++;
      $display("[ERROR] pin_discipline: we_n and oe_n both low at %0t", $time);
    end
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run did not complete", watchdog_cycles);
    $display("Finished with errors");
    $finish;
  end

  // expected SRAM word for pattern p at address a
  function automatic sram_bist_pkg::data_t pattern_word(input int p,
                                                        input sram_bist_pkg::addr_t a,
                                                        input sram_bist_pkg::data_t s);
    sram_bist_pkg::data_t cb;
    cb = a[0] ? 16'hAAAA : 16'h5555;
    case (p)
      0:       return 16'h0000;
      1:       return 16'hFFFF;
      2:       return cb;
      3:       return ~cb;
      4:       return {8'h00, a};
      default: return s ^ {8'h00, a};
    endcase
  endfunction

  // first pattern whose word disagrees with the stuck bit
  task automatic predict(input sram_bist_pkg::data_t s, input logic late, output logic f,
                         output sram_bist_pkg::pat_t p, output sram_bist_pkg::data_t d);
    sram_bist_pkg::data_t w;
    f = 1'b0;
    p = '0;
    d = '0;
    if (fault_en) begin
      for (int i = (late ? 5 : 0); i < 6; i++) begin
        w = pattern_word(i, fault_addr, s);
        if (!f && (w[fault_bit] != fault_val)) begin
          f = 1'b1;
          p = sram_bist_pkg::pat_t'(i);
          d = w;
          d[fault_bit] = fault_val;
        end
      end
    end
  endtask

  task automatic compare(input string what, input logic [15:0] actual,
                         input logic [15:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, expected, actual);
      test_errors++;
    end
  endtask

  task automatic end_test();
    if (test_errors == 0) $display("[PASS] %s", test_name);
    else $display("[FAIL] %s, %0d errors", test_name, test_errors);
    errors += test_errors;
    test_errors = 0;
    tests++;
  endtask

  task automatic pick_fault(input logic en);
    fault_en   = en;
    fault_addr = sram_bist_pkg::addr_t'($urandom_range(255));
    fault_bit  = 4'($urandom_range(15));
    fault_val  = 1'($urandom_range(1));
  endtask

  // late faults go live once the run reaches pattern 5
  task automatic run_bist(input sram_bist_pkg::data_t s, input logic late, input int busy_at);
    int cycles;
    logic exp_fail;
    sram_bist_pkg::pat_t exp_pat;
    sram_bist_pkg::data_t exp_data;
    fault_live = fault_en && !late;
    @(posedge clk);
    #1;
    seed  = s;
    start = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
    if (done || fail) begin
      $display("%s: done or fail still set after start", test_name);
      test_errors++;
    end
    cycles = 0;
    while (!done && cycles < run_limit) begin
      @(posedge clk);
      #1;
      cycles++;
      if (late && fault_en && fail_pattern == sram_bist_pkg::pat_t'(5)) fault_live = 1'b1;
      start = (cycles == busy_at);
      if (start) seed = ~s;
    end
    start = 1'b0;
    if (!done) begin
      $display("%s: no done within %0d cycles", test_name, run_limit);
      test_errors++;
    end
    predict(s, late, exp_fail, exp_pat, exp_data);
    compare("fail", 16'(fail), 16'(exp_fail));
    compare("pass", 16'(pass), 16'(!exp_fail));
    if (exp_fail) begin
      compare("fail_pattern", 16'(fail_pattern), 16'(exp_pat));
      compare("fail_addr", 16'(fail_addr), 16'(fault_addr));
      compare("fail_data", fail_data, exp_data);
    end else begin
      compare("fail_addr", 16'(fail_addr), 16'h0000);
    end
  endtask

  initial begin
    sram_bist_pkg::data_t s1;
    sram_bist_pkg::data_t w5;
    reset       = 1'b1;
    start       = 1'b0;
    seed        = '0;
    errors      = 0;
    test_errors = 0;
    tests       = 0;
    pick_fault(1'b0);
    fault_live  = 1'b0;
    void'($urandom(82386));
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;

    test_name = "reset_strobes";
    compare("we_n oe_n ce_n", 16'({sram_we_n, sram_oe_n, sram_ce_n}), 16'h0007);
    end_test();

    test_name = "clean_run";
    pick_fault(1'b0);
    run_bist(sram_bist_pkg::data_t'($urandom), 1'b0, 0);
    end_test();

    test_name = "stuck_at";
    pick_fault(1'b1);
    run_bist(sram_bist_pkg::data_t'($urandom), 1'b0, 0);
    end_test();

    test_name = "seed_pattern";
    pick_fault(1'b1);
    run_bist(sram_bist_pkg::data_t'($urandom), 1'b1, 0);
    end_test();

    test_name = "back_to_back";
    pick_fault(1'b1);
    run_bist(sram_bist_pkg::data_t'($urandom), 1'b0, 0);
    pick_fault(1'b1);
    run_bist(sram_bist_pkg::data_t'($urandom), 1'b1, 0);
    end_test();

    // fault shows only with the first seed because the busy start inverts the seed
    test_name = "start_while_busy";
    pick_fault(1'b1);
    s1 = sram_bist_pkg::data_t'($urandom);
    w5 = pattern_word(5, fault_addr, s1);
    fault_val = ~w5[fault_bit];
    run_bist(s1, 1'b1, 200 + int'($urandom_range(1000)));
    end_test();

    test_name = "pin_discipline";
    test_errors = pin_errors;
    end_test();

    $display("tests: %0d, errors: %0d", tests, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- flist.f
design/sram_bist_pkg.sv
design/axil_if.sv
design/sram_axil_ctrl.sv
design/pattern_gen.sv
design/bist_sequencer.sv
design/expected_fifo.sv
design/read_checker.sv
design/sram_bist_top.sv
verif/sram_model.sv
verif/tb_sram_bist.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the SRAM BIST testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -j 0 --top-module tb_sram_bist \
  -f flist.f -o sim_tb > build.log 2>&1 \
  && ./obj_dir/sim_tb > sim.log 2>&1

grep -qx "Finished with no errors" sim.log 2>/dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed, see build.log and sim.log"; exit 1; }
